//--- hw/rs_consts.svh
// Reservation station constants
`ifndef RS_CONSTS_SVH
`define RS_CONSTS_SVH

// Widths and depths
`define RS_XLEN             32  // Data width
`define RS_ROB_IDX_LEN      4   // ROB tag width
`define RS_DEPTH            4   // Station entries, power of 2
`define RS_EU_CTL_LEN       3   // ALU opcode width
`define RS_EXCEPT_LEN       2   // EU exception code width
`define RS_ROB_EXCEPT_LEN   4   // ROB exception code width
`define RS_EXC_OVERFLOW     1   // Signed overflow code

// ALU operation codes
`define RS_OP_ADD   3'd0
`define RS_OP_SUB   3'd1
`define RS_OP_AND   3'd2
`define RS_OP_OR    3'd3
`define RS_OP_XOR   3'd4
`define RS_OP_SLL   3'd5
`define RS_OP_SRL   3'd6
`define RS_OP_ADDO  3'd7    // Add with overflow trap
`endif

//--- hw/rs_pkg.sv
// Reservation station types
`include "rs_consts.svh"

package rs_pkg;

    // Operand and result data
    typedef logic [`RS_XLEN-1:0] xlen_t;

    // Reorder buffer tag
    typedef logic [`RS_ROB_IDX_LEN-1:0] rob_idx_t;

    // Entry index inside the station
    typedef logic [$clog2(`RS_DEPTH)-1:0] rs_idx_t;

    // ALU opcode
    typedef logic [`RS_EU_CTL_LEN-1:0] eu_ctl_t;

    // Exception code as produced by the EU
    typedef logic [`RS_EXCEPT_LEN-1:0] except_code_t;

    // Exception code as stored in the ROB, zero-extended
    typedef logic [`RS_ROB_EXCEPT_LEN-1:0] rob_except_t;

endpackage

//--- hw/eu_if.sv
// Station to execution unit link
`timescale 1ns/1ps

interface eu_if;

    // Dispatch side, station to EU
    logic                   issue_valid;    // Operation transfers on every high cycle
    rs_pkg::eu_ctl_t        ctl;            // Opcode
    rs_pkg::xlen_t          rs1;            // First operand
    rs_pkg::xlen_t          rs2;            // Second operand or immediate
    rs_pkg::rs_idx_t        entry_idx;      // Travels with the op, comes back with the result

    // Result side, EU to station
    logic                   res_valid;
    rs_pkg::rs_idx_t        res_entry_idx;  // Entry to write back
    rs_pkg::xlen_t          result;
    logic                   except_raised;
    rs_pkg::except_code_t   except_code;

    modport rs (
        output issue_valid, ctl, rs1, rs2, entry_idx,
        input  res_valid, res_entry_idx, result, except_raised, except_code
    );

    modport eu (
        input  issue_valid, ctl, rs1, rs2, entry_idx,
        output res_valid, res_entry_idx, result, except_raised, except_code
    );

endinterface

//--- hw/prio_enc.sv
// Lowest-index priority encoder
`timescale 1ns/1ps

module prio_enc #(
    parameter int N = 4                     // Number of request lines
) (
    input  logic [N-1:0]            lines_i,
    output logic [$clog2(N)-1:0]    enc_o,  // Index of the lowest set line
    output logic                    valid_o // Any line set
);

    always_comb begin
        enc_o   = '0;
        valid_o = 1'b0;
        // Scan downwards so the lowest set line is written last
        for (int i = N - 1; i >= 0; i--) begin
            if (lines_i[i]) begin
                enc_o   = i[$clog2(N)-1:0];
                valid_o = 1'b1;
            end
        end
    end

endmodule

//--- hw/generic_rs.sv
// Generic reservation station
`timescale 1ns/1ps
`include "rs_consts.svh"

module generic_rs (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,        // Synchronous, drops every entry

    // Issue stage
    input  logic                    issue_valid_i,
    output logic                    issue_ready_o,
    input  rs_pkg::eu_ctl_t         eu_ctl_i,
    input  logic                    rs1_ready_i,
    input  rs_pkg::rob_idx_t        rs1_idx_i,
    input  rs_pkg::xlen_t           rs1_value_i,
    input  logic                    rs2_ready_i,
    input  rs_pkg::rob_idx_t        rs2_idx_i,
    input  rs_pkg::xlen_t           rs2_value_i,    // May hold an immediate
    input  rs_pkg::rob_idx_t        dest_idx_i,

    // Execution unit
    eu_if.rs                        eu,

    // CDB snoop
    input  logic                    cdb_valid_i,
    input  rs_pkg::rob_idx_t        cdb_idx_i,
    input  rs_pkg::xlen_t           cdb_data_i,
    input  logic                    cdb_except_raised_i,

    // CDB request
    input  logic                    cdb_ready_i,
    output logic                    cdb_valid_o,
    output rs_pkg::rob_idx_t        cdb_idx_o,
    output rs_pkg::xlen_t           cdb_data_o,
    output logic                    cdb_except_raised_o,
    output rs_pkg::rob_except_t     cdb_except_o
);

    localparam int DEPTH = `RS_DEPTH;

    // Entry control state
    logic [DEPTH-1:0]       valid_q;        // Entry holds an instruction
    logic [DEPTH-1:0]       busy_q;         // Sent to the EU
    logic [DEPTH-1:0]       done_q;         // Result written back
    logic [DEPTH-1:0]       rs1_rdy_q;
    logic [DEPTH-1:0]       rs2_rdy_q;

    // Entry payload
    rs_pkg::eu_ctl_t        ctl_q      [DEPTH];
    rs_pkg::rob_idx_t       rs1_tag_q  [DEPTH];
    rs_pkg::rob_idx_t       rs2_tag_q  [DEPTH];
    rs_pkg::xlen_t          rs1_val_q  [DEPTH];
    rs_pkg::xlen_t          rs2_val_q  [DEPTH];
    rs_pkg::rob_idx_t       dest_q     [DEPTH];
    rs_pkg::xlen_t          res_q      [DEPTH];
    logic [DEPTH-1:0]       exc_raised_q;
    rs_pkg::except_code_t   exc_code_q [DEPTH];

    // Selectors
    rs_pkg::rs_idx_t        free_idx, ex_idx, cdb_enc_idx, cdb_sel_idx;
    logic                   free_valid, ex_valid, cdb_enc_valid;
    rs_pkg::rs_idx_t        cdb_hold_idx_q; // Entry offered while the CDB stalls
    logic                   cdb_hold_q;

    // Per-entry strobes
    logic [DEPTH-1:0]       ex_cand, done_cand;
    logic [DEPTH-1:0]       snoop1_hit, snoop2_hit;
    logic [DEPTH-1:0]       ins_sel, ex_sel, wb_sel, pop_sel;
    logic                   rs_insert, rs_pop, snoop_ok;
    logic                   ins1_byp, ins2_byp;

    // -------------------------------------------------
    // Status and strobes
    // -------------------------------------------------
    assign rs_insert = issue_valid_i & issue_ready_o;
    assign rs_pop    = cdb_valid_o & cdb_ready_i;
    assign snoop_ok  = cdb_valid_i & ~cdb_except_raised_i;  // Faulting results wake nobody

    // Broadcast on the insert edge is forwarded into the new entry
    assign ins1_byp = snoop_ok & ~rs1_ready_i & (rs1_idx_i == cdb_idx_i);
    assign ins2_byp = snoop_ok & ~rs2_ready_i & (rs2_idx_i == cdb_idx_i);

    assign ex_cand   = valid_q & ~busy_q & rs1_rdy_q & rs2_rdy_q;  // Both operands present
    assign done_cand = valid_q & done_q;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            snoop1_hit[i] = snoop_ok & valid_q[i] & ~rs1_rdy_q[i] & (rs1_tag_q[i] == cdb_idx_i);
            snoop2_hit[i] = snoop_ok & valid_q[i] & ~rs2_rdy_q[i] & (rs2_tag_q[i] == cdb_idx_i);
            ins_sel[i]    = rs_insert & (free_idx == rs_pkg::rs_idx_t'(i));
            ex_sel[i]     = eu.issue_valid & (ex_idx == rs_pkg::rs_idx_t'(i));
            wb_sel[i]     = eu.res_valid & (eu.res_entry_idx == rs_pkg::rs_idx_t'(i));
            pop_sel[i]    = rs_pop & (cdb_sel_idx == rs_pkg::rs_idx_t'(i));
        end
    end

    // -------------------------------------------------
    // Entry control update
    // -------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q        <= '0;
            busy_q         <= '0;
            done_q         <= '0;
            rs1_rdy_q      <= '0;
            rs2_rdy_q      <= '0;
            cdb_hold_q     <= 1'b0;
            cdb_hold_idx_q <= '0;
        end else if (flush_i) begin     // Status bits are enough to drop everything
            valid_q        <= '0;
            busy_q         <= '0;
            done_q         <= '0;
            rs1_rdy_q      <= '0;
            rs2_rdy_q      <= '0;
            cdb_hold_q     <= 1'b0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (ins_sel[i]) begin   // Free entry, nothing else can touch it
                    valid_q[i]   <= 1'b1;
                    busy_q[i]    <= 1'b0;
                    done_q[i]    <= 1'b0;
                    rs1_rdy_q[i] <= rs1_ready_i | ins1_byp;
                    rs2_rdy_q[i] <= rs2_ready_i | ins2_byp;
                end else begin
                    if (ex_sel[i])     busy_q[i]    <= 1'b1;  // Never picked again
                    if (wb_sel[i])     done_q[i]    <= 1'b1;
                    if (snoop1_hit[i]) rs1_rdy_q[i] <= 1'b1;
                    if (snoop2_hit[i]) rs2_rdy_q[i] <= 1'b1;
                    if (pop_sel[i]) begin
                        valid_q[i] <= 1'b0;
                        busy_q[i]  <= 1'b0;
                        done_q[i]  <= 1'b0;
                    end
                end
            end
            // Freeze the CDB choice until the arbiter takes it
            cdb_hold_q     <= cdb_valid_o & ~cdb_ready_i;
            cdb_hold_idx_q <= cdb_sel_idx;
        end
    end

    // -------------------------------------------------
    // Entry payload update
    // -------------------------------------------------
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (ins_sel[i]) begin
                ctl_q[i]     <= eu_ctl_i;
                rs1_tag_q[i] <= rs1_idx_i;
                rs2_tag_q[i] <= rs2_idx_i;
                dest_q[i]    <= dest_idx_i;
                rs1_val_q[i] <= ins1_byp ? cdb_data_i : rs1_value_i;
                rs2_val_q[i] <= ins2_byp ? cdb_data_i : rs2_value_i;
            end else begin
                if (snoop1_hit[i]) rs1_val_q[i] <= cdb_data_i;
                if (snoop2_hit[i]) rs2_val_q[i] <= cdb_data_i;
            end
            if (wb_sel[i]) begin    // EU write-back port
                res_q[i]        <= eu.result;
                exc_raised_q[i] <= eu.except_raised;
                exc_code_q[i]   <= eu.except_code;
            end
        end
    end

    // -------------------------------------------------
    // Selectors
    // -------------------------------------------------
    prio_enc #(.N(DEPTH)) u_free_enc (
        .lines_i (~valid_q),
        .enc_o   (free_idx),
        .valid_o (free_valid)
    );

    prio_enc #(.N(DEPTH)) u_ex_enc (
        .lines_i (ex_cand),
        .enc_o   (ex_idx),
        .valid_o (ex_valid)
    );

    prio_enc #(.N(DEPTH)) u_cdb_enc (
        .lines_i (done_cand),
        .enc_o   (cdb_enc_idx),
        .valid_o (cdb_enc_valid)
    );

    // Outputs
    assign issue_ready_o = free_valid;

    assign eu.issue_valid = ex_valid;   // EU never stalls
    assign eu.ctl         = ctl_q[ex_idx];
    assign eu.rs1         = rs1_val_q[ex_idx];
    assign eu.rs2         = rs2_val_q[ex_idx];
    assign eu.entry_idx   = ex_idx;

    assign cdb_sel_idx         = cdb_hold_q ? cdb_hold_idx_q : cdb_enc_idx;
    assign cdb_valid_o         = cdb_hold_q | cdb_enc_valid;
    assign cdb_idx_o           = dest_q[cdb_sel_idx];
    assign cdb_data_o          = res_q[cdb_sel_idx];
    assign cdb_except_raised_o = exc_raised_q[cdb_sel_idx];
    assign cdb_except_o        = {{(`RS_ROB_EXCEPT_LEN - `RS_EXCEPT_LEN){1'b0}},
                                  exc_code_q[cdb_sel_idx]};  // Zero-extend to ROB width

endmodule

//--- hw/alu_unit.sv
// Two-stage pipelined integer ALU
`timescale 1ns/1ps
`include "rs_consts.svh"

module alu_unit (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    flush_i,    // Kills both stages
    eu_if.eu        eu
);

    localparam int SHAMT_W = $clog2(`RS_XLEN);

    // Stage 1 datapath
    rs_pkg::xlen_t          sum;
    rs_pkg::xlen_t          alu_res;
    logic                   add_ovf;
    logic                   alu_exc;

    // Pipeline registers
    logic                   s1_valid_q, s2_valid_q;
    rs_pkg::xlen_t          s1_res_q, s2_res_q;
    rs_pkg::rs_idx_t        s1_idx_q, s2_idx_q;
    logic                   s1_exc_q, s2_exc_q;

    // -------------------------------------------------
    // Stage 1 compute
    // -------------------------------------------------
    assign sum     = eu.rs1 + eu.rs2;
    // Same operand signs, different result sign
    assign add_ovf = (eu.rs1[`RS_XLEN-1] == eu.rs2[`RS_XLEN-1]) &&
                     (sum[`RS_XLEN-1] != eu.rs1[`RS_XLEN-1]);

    always_comb begin
        alu_exc = 1'b0;
        case (eu.ctl)
            `RS_OP_ADD:  alu_res = sum;
            `RS_OP_SUB:  alu_res = eu.rs1 - eu.rs2;
            `RS_OP_AND:  alu_res = eu.rs1 & eu.rs2;
            `RS_OP_OR:   alu_res = eu.rs1 | eu.rs2;
            `RS_OP_XOR:  alu_res = eu.rs1 ^ eu.rs2;
            `RS_OP_SLL:  alu_res = eu.rs1 << eu.rs2[SHAMT_W-1:0];
            `RS_OP_SRL:  alu_res = eu.rs1 >> eu.rs2[SHAMT_W-1:0];
            `RS_OP_ADDO: begin
                alu_res = sum;
                alu_exc = add_ovf;  // Trap on signed overflow
            end
            default:     alu_res = '0;
        endcase
    end

    // -------------------------------------------------
    // Pipeline
    // -------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (flush_i) begin     // In-flight results are dropped
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= eu.issue_valid;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_res_q <= alu_res;        // Stage 1 result
        s1_idx_q <= eu.entry_idx;
        s1_exc_q <= alu_exc;
        s2_res_q <= s1_res_q;       // Stage 2 holds the output
        s2_idx_q <= s1_idx_q;
        s2_exc_q <= s1_exc_q;
    end

    assign eu.res_valid     = s2_valid_q;
    assign eu.res_entry_idx = s2_idx_q;
    assign eu.result        = s2_res_q;
    assign eu.except_raised = s2_exc_q;
    assign eu.except_code   = s2_exc_q ? rs_pkg::except_code_t'(`RS_EXC_OVERFLOW) : '0;

endmodule

//--- hw/rs_top.sv
// Reservation station issue slice top
`timescale 1ns/1ps

module rs_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,

    // Issue
    input  logic                    issue_valid_i,
    output logic                    issue_ready_o,
    input  rs_pkg::eu_ctl_t         eu_ctl_i,
    input  logic                    rs1_ready_i,
    input  rs_pkg::rob_idx_t        rs1_idx_i,
    input  rs_pkg::xlen_t           rs1_value_i,
    input  logic                    rs2_ready_i,
    input  rs_pkg::rob_idx_t        rs2_idx_i,
    input  rs_pkg::xlen_t           rs2_value_i,
    input  rs_pkg::rob_idx_t        dest_idx_i,

    // CDB snoop
    input  logic                    cdb_valid_i,
    input  rs_pkg::rob_idx_t        cdb_idx_i,
    input  rs_pkg::xlen_t           cdb_data_i,
    input  logic                    cdb_except_raised_i,

    // CDB result
    input  logic                    cdb_ready_i,
    output logic                    cdb_valid_o,
    output rs_pkg::rob_idx_t        cdb_idx_o,
    output rs_pkg::xlen_t           cdb_data_o,
    output logic                    cdb_except_raised_o,
    output rs_pkg::rob_except_t     cdb_except_o
);

    eu_if eu_bus ();    // Station to ALU link

    generic_rs u_rs (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .flush_i             (flush_i),
        .issue_valid_i       (issue_valid_i),
        .issue_ready_o       (issue_ready_o),
        .eu_ctl_i            (eu_ctl_i),
        .rs1_ready_i         (rs1_ready_i),
        .rs1_idx_i           (rs1_idx_i),
        .rs1_value_i         (rs1_value_i),
        .rs2_ready_i         (rs2_ready_i),
        .rs2_idx_i           (rs2_idx_i),
        .rs2_value_i         (rs2_value_i),
        .dest_idx_i          (dest_idx_i),
        .eu                  (eu_bus),
        .cdb_valid_i         (cdb_valid_i),
        .cdb_idx_i           (cdb_idx_i),
        .cdb_data_i          (cdb_data_i),
        .cdb_except_raised_i (cdb_except_raised_i),
        .cdb_ready_i         (cdb_ready_i),
        .cdb_valid_o         (cdb_valid_o),
        .cdb_idx_o           (cdb_idx_o),
        .cdb_data_o          (cdb_data_o),
        .cdb_except_raised_o (cdb_except_raised_o),
        .cdb_except_o        (cdb_except_o)
    );

    alu_unit u_alu (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .eu      (eu_bus)
    );

endmodule

//--- dv/tb_rs_top.sv
// Reservation station testbench
`timescale 1ns/1ps
`include "rs_consts.svh"

module tb_rs_top;

    localparam int TOTAL_OPS = 58;              // Issues over all tests

    logic clk_i = 1'b0;
    logic rst_n_i, flush_i, issue_valid_i, issue_ready_o;
    rs_pkg::eu_ctl_t eu_ctl_i;
    logic rs1_ready_i, rs2_ready_i;
    rs_pkg::rob_idx_t rs1_idx_i, rs2_idx_i, dest_idx_i, cdb_idx_i, cdb_idx_o;
    rs_pkg::xlen_t rs1_value_i, rs2_value_i, cdb_data_i, cdb_data_o;
    logic cdb_valid_i, cdb_except_raised_i, cdb_ready_i, cdb_valid_o, cdb_except_raised_o;
    rs_pkg::rob_except_t cdb_except_o;

    // Scoreboard written by the issuer and consumed by the compare process
    rs_pkg::xlen_t exp_data [16];
    logic exp_exc [16];
    int exp_gen [16];                           // Issues per destination tag
    int got_gen [16];                           // CDB transfers per destination tag
    int issued_cnt, popped_cnt, err_cnt, cmp_err_cnt, tests_ok, tests_bad;
    logic [36:0] snoop_mem [64];                // {fault, tag, data} broadcasts to send
    int snoop_wr, snoop_rd;
    int bp_mode;                                // 0 hold, 1 ready, 2 random
    logic [31:0] rng, bus_rng;
    logic [36:0] snoop_item;
    rs_pkg::rob_except_t exp_code;
    rs_pkg::rob_idx_t snoop_tag, dest_tag;
    logic r1, r2;
    int e0;

    rs_top rs_top_i (.*);

    always #20 clk_i = ~clk_i;                  // 40 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected {exception, data} from the opcode rules
    function automatic logic [32:0] alu_ref(input rs_pkg::eu_ctl_t op,
                                            input rs_pkg::xlen_t a, input rs_pkg::xlen_t b);
        longint wide;
        logic ovf;
        rs_pkg::xlen_t d;
        ovf = 1'b0;
        case (op)
            `RS_OP_ADD:  d = a + b;
            `RS_OP_SUB:  d = a - b;
            `RS_OP_AND:  d = a & b;
            `RS_OP_OR:   d = a | b;
            `RS_OP_XOR:  d = a ^ b;
            `RS_OP_SLL:  d = a << b[4:0];
            `RS_OP_SRL:  d = a >> b[4:0];
            `RS_OP_ADDO: begin
                d    = a + b;
                wide = longint'($signed(a)) + longint'($signed(b));   // Exact signed sum
                ovf  = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
            end
            default:     d = '0;
        endcase
        return {ovf, d};
    endfunction

    function automatic int total_errs();
        return err_cnt + cmp_err_cnt;
    endfunction

    // Offer one instruction until accepted; a missing operand carries the snoop value in v1/v2
    task automatic issue_op(input rs_pkg::eu_ctl_t op, input logic rd1, input rs_pkg::rob_idx_t t1,
                            input rs_pkg::xlen_t v1, input logic rd2, input rs_pkg::rob_idx_t t2,
                            input rs_pkg::xlen_t v2, input rs_pkg::rob_idx_t dest,
                            input logic track, input logic snoop);
        logic [32:0] ref_v;
        while (track && exp_gen[dest] != got_gen[dest]) begin
            @(posedge clk_i);                   // A ROB tag is reused only once retired
            #2;
        end
        ref_v = alu_ref(op, v1, v2);
        issue_valid_i = 1'b1;
        eu_ctl_i      = op;
        rs1_ready_i   = rd1;
        rs1_idx_i     = t1;
        rs1_value_i   = rd1 ? v1 : ~v1;         // Stale value if the operand is pending
        rs2_ready_i   = rd2;
        rs2_idx_i     = t2;
        rs2_value_i   = rd2 ? v2 : ~v2;
        dest_idx_i    = dest;
        @(negedge clk_i);
        while (!issue_ready_o) @(negedge clk_i);
        @(posedge clk_i);                       // Accepted on this edge
        #2;
        issue_valid_i = 1'b0;
        if (track) begin
            exp_data[dest] = ref_v[31:0];
            exp_exc[dest]  = ref_v[32];
            exp_gen[dest]  = exp_gen[dest] + 1;
            issued_cnt     = issued_cnt + 1;
        end
        if (snoop && !rd1) begin
            snoop_mem[snoop_wr % 64] = {1'b0, t1, v1};
            snoop_wr = snoop_wr + 1;
        end
        if (snoop && !rd2) begin
            snoop_mem[snoop_wr % 64] = {1'b0, t2, v2};
            snoop_wr = snoop_wr + 1;
        end
    endtask

    task automatic push_snoop(input logic fault, input rs_pkg::rob_idx_t tag,
                              input rs_pkg::xlen_t d);
        snoop_mem[snoop_wr % 64] = {fault, tag, d};
        snoop_wr = snoop_wr + 1;
    endtask

    // Wait for every tracked result, then a few idle cycles for stray ones
    task automatic drain();
        bp_mode = 1;
        while (issued_cnt != popped_cnt) @(posedge clk_i);
        repeat (4) @(posedge clk_i);
        #2;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (total_errs() == errs_before) begin
            $display("Test %s: ok", name);
            tests_ok = tests_ok + 1;
        end else begin
            $display("Test %s: failed with %0d errors", name, total_errs() - errs_before);
            tests_bad = tests_bad + 1;
        end
    endtask

    // --------------------------------------------------
    // CDB arbiter and snoop source
    // --------------------------------------------------
    initial begin
        cdb_valid_i = 1'b0;
        cdb_idx_i = '0;
        cdb_data_i = '0;
        cdb_except_raised_i = 1'b0;
        cdb_ready_i = 1'b0;
        snoop_rd = 0;
        bus_rng = lcg_next(32'd88);
        forever begin
            @(posedge clk_i);
            #2;
            bus_rng = lcg_next(bus_rng);
            case (bp_mode)
                0:       cdb_ready_i = 1'b0;
                1:       cdb_ready_i = 1'b1;
                default: cdb_ready_i = bus_rng[16] | bus_rng[17];   // Ready 3 cycles in 4
            endcase
            if (snoop_rd != snoop_wr && (bp_mode != 2 || bus_rng[20])) begin
                snoop_item          = snoop_mem[snoop_rd % 64];
                cdb_valid_i         = 1'b1;
                cdb_except_raised_i = snoop_item[36];
                cdb_idx_i           = snoop_item[35:32];
                cdb_data_i          = snoop_item[31:0];
                snoop_rd            = snoop_rd + 1;
            end else begin
                cdb_valid_i = 1'b0;
            end
        end
    end

    // Compare each CDB transfer mid-cycle before the edge that takes it
    always @(negedge clk_i) begin
        if (rst_n_i && !flush_i && cdb_valid_o && cdb_ready_i) begin
            if (exp_gen[cdb_idx_o] == got_gen[cdb_idx_o]) begin
                $display("Unexpected CDB result for tag %h, data %h", cdb_idx_o, cdb_data_o);
                cmp_err_cnt = cmp_err_cnt + 1;
            end else begin
                exp_code = exp_exc[cdb_idx_o] ? rs_pkg::rob_except_t'(`RS_EXC_OVERFLOW) : '0;
                if (cdb_data_o !== exp_data[cdb_idx_o]) begin
                    $display("** Error tag %h: cdb_data_o = %h, expected %h",
                             cdb_idx_o, cdb_data_o, exp_data[cdb_idx_o]);
                    cmp_err_cnt = cmp_err_cnt + 1;
                end
                if (cdb_except_raised_o !== exp_exc[cdb_idx_o]) begin
                    $display("** Error tag %h: cdb_except_raised_o = %h, expected %h",
                             cdb_idx_o, cdb_except_raised_o, exp_exc[cdb_idx_o]);
                    cmp_err_cnt = cmp_err_cnt + 1;
                end
                if (cdb_except_o !== exp_code) begin
                    $display("** Error tag %h: cdb_except_o = %h, expected %h",
                             cdb_idx_o, cdb_except_o, exp_code);
                    cmp_err_cnt = cmp_err_cnt + 1;
                end
                got_gen[cdb_idx_o] = got_gen[cdb_idx_o] + 1;
                popped_cnt = popped_cnt + 1;
            end
        end
    end

    // Watchdog sized from the operation count
    initial begin
        repeat (TOTAL_OPS * 40 + 200) @(posedge clk_i);
        $display("Watchdog expired before the tests finished");
        $display(">>> FAIL");
        $finish;
    end

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    initial begin
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        issue_valid_i = 1'b0;
        eu_ctl_i = '0;
        rs1_ready_i = 1'b0;
        rs1_idx_i = '0;
        rs1_value_i = '0;
        rs2_ready_i = 1'b0;
        rs2_idx_i = '0;
        rs2_value_i = '0;
        dest_idx_i = '0;
        for (int i = 0; i < 16; i++) begin
            exp_gen[i] = 0;
            got_gen[i] = 0;
        end
        issued_cnt = 0;
        popped_cnt = 0;
        err_cnt = 0;
        cmp_err_cnt = 0;
        tests_ok = 0;
        tests_bad = 0;
        snoop_wr = 0;
        bp_mode = 1;
        rng = 32'd88;
        repeat (10) @(posedge clk_i);           // Reset for 10 cycles
        #2;
        rst_n_i = 1'b1;
        @(posedge clk_i);
        #2;

        e0 = total_errs();                      // Every opcode, operands ready
        for (int op = 0; op < 8; op++) begin
            rng = lcg_next(rng);
            issue_op(rs_pkg::eu_ctl_t'(op), 1'b1, '0, rng, 1'b1, '0, lcg_next(rng),
                     rs_pkg::rob_idx_t'(op), 1'b1, 1'b0);
        end
        drain();
        finish_test("all_ops", e0);

        e0 = total_errs();                      // Overflow trap on ADDO
        issue_op(`RS_OP_ADDO, 1'b1, '0, 32'h7fff_ffff, 1'b1, '0, 32'h1, 4'd8, 1'b1, 1'b0);
        issue_op(`RS_OP_ADDO, 1'b1, '0, 32'h8000_0000, 1'b1, '0, 32'hffff_ffff, 4'd9, 1'b1, 1'b0);
        issue_op(`RS_OP_ADDO, 1'b1, '0, 32'h5, 1'b1, '0, 32'h6, 4'd10, 1'b1, 1'b0);
        drain();
        finish_test("overflow", e0);

        e0 = total_errs();                      // Wake-up by snoop after an ignored faulting one
        bp_mode = 0;
        issue_op(`RS_OP_SUB, 1'b0, 4'd9, 32'h1234_5678, 1'b0, 4'd10, 32'h1111, 4'd3, 1'b1, 1'b0);
        push_snoop(1'b1, 4'd9, 32'hdead_beef);
        push_snoop(1'b1, 4'd10, 32'hbad0_0bad);
        repeat (10) @(negedge clk_i);           // Long enough for a wrong wake-up to finish
        if (cdb_valid_o) begin
            $display("Entry woke up on a faulting CDB broadcast");
            err_cnt = err_cnt + 1;
        end
        @(posedge clk_i);
        #2;
        push_snoop(1'b0, 4'd9, 32'h1234_5678);
        push_snoop(1'b0, 4'd10, 32'h1111);
        drain();
        finish_test("snoop", e0);

        e0 = total_errs();                      // Fill the station under back-pressure
        bp_mode = 0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            rng = lcg_next(rng);
            issue_op(rs_pkg::eu_ctl_t'(rng[30:28]), 1'b1, '0, rng, 1'b1, '0, ~rng,
                     rs_pkg::rob_idx_t'(11 + i), 1'b1, 1'b0);
        end
        repeat (6) @(negedge clk_i);            // All results finished and held
        if (issue_ready_o) begin
            $display("issue_ready_o still high with every entry held");
            err_cnt = err_cnt + 1;
        end
        @(posedge clk_i);
        #2;
        drain();
        finish_test("backpressure", e0);

        e0 = total_errs();                      // Flush a held result and one in flight
        bp_mode = 0;
        issue_op(`RS_OP_ADD, 1'b1, '0, 32'h10, 1'b1, '0, 32'h20, 4'd5, 1'b0, 1'b0);
        @(negedge clk_i);
        while (!cdb_valid_o) @(negedge clk_i);
        @(posedge clk_i);
        #2;
        issue_op(`RS_OP_XOR, 1'b1, '0, 32'h33, 1'b1, '0, 32'h44, 4'd6, 1'b0, 1'b0);
        @(posedge clk_i);                       // XOR now in the ALU
        #2;
        flush_i = 1'b1;
        @(posedge clk_i);
        #2;
        flush_i = 1'b0;
        @(negedge clk_i);
        if (cdb_valid_o || !issue_ready_o) begin
            $display("Station not empty after flush");
            err_cnt = err_cnt + 1;
        end
        @(posedge clk_i);
        #2;
        bp_mode = 1;
        repeat (8) @(posedge clk_i);            // Flushed results must never show
        #2;
        finish_test("flush", e0);

        e0 = total_errs();                      // Random mix with snoops and back-pressure
        bp_mode = 2;
        snoop_tag = '0;
        dest_tag = '0;
        for (int k = 0; k < 40; k++) begin
            rng = lcg_next(rng);
            r1 = rng[27] | rng[26];
            r2 = rng[25] | rng[24];
            issue_op(rs_pkg::eu_ctl_t'(rng[30:28]), r1, snoop_tag, lcg_next(rng), r2,
                     snoop_tag + (r1 ? 4'd0 : 4'd1), lcg_next(lcg_next(rng)), dest_tag,
                     1'b1, 1'b1);
            snoop_tag = snoop_tag + (r1 ? 4'd0 : 4'd1) + (r2 ? 4'd0 : 4'd1);
            dest_tag = dest_tag + 4'd1;
        end
        drain();
        finish_test("random", e0);

        $display("Tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, total_errs());
        if (total_errs() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+hw
hw/rs_pkg.sv
hw/eu_if.sv
hw/prio_enc.sv
hw/generic_rs.sv
hw/alu_unit.sv
hw/rs_top.sv
dv/tb_rs_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 --timescale 1ns/1ps
TOP       = tb_rs_top
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails unless the simulation prints the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
